//--- cnn_loader_config.svh
`ifndef CNN_LOADER_CONFIG_SVH
`define CNN_LOADER_CONFIG_SVH

// array sizes
`define NUM_PE          4
`define DATA_W          8
`define ADDR_W          6       // 64 bytes of local memory
`define ACC_W           20

// sequencer schedule
`define LOAD_STAGES     27
`define GROUP_LEN       9       // 8 loads then one accumulate

// host bus and register map
`define APB_AW          12
`define REG_CTRL        12'h000
`define REG_STATUS      12'h004
`define MEM_BASE        12'h100
`define RES_BASE        12'h200

`endif

//--- bus_pkg.sv
`include "cnn_loader_config.svh"

package bus_pkg;

    // host to slave for one transfer
    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`APB_AW-1:0]     paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    // slave to host
    typedef struct packed {
        logic [31:0]            prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

//--- loader_pkg.sv
`include "cnn_loader_config.svh"

package loader_pkg;

    // feature bytes are unsigned pixels
    typedef logic [`DATA_W-1:0] feature_t;

    // weights are two's complement
    typedef logic signed [`DATA_W-1:0] weight_t;

    typedef logic signed [`ACC_W-1:0] acc_t;

    typedef logic [$clog2(`LOAD_STAGES)-1:0] stage_t;

    // one-hot per PE enables for a single stage
    typedef struct packed {
        logic [`NUM_PE-1:0]     feature_en;
        logic [`NUM_PE-1:0]     weight_en;
        logic [`NUM_PE-1:0]     acc_en;
    } load_ctrl_t;

endpackage

//--- data_mem.sv
`include "cnn_loader_config.svh"

module data_mem (
    input  logic                clk_i,
    input  logic                we_i,
    input  logic [`ADDR_W-1:0]  waddr_i,
    input  logic [`DATA_W-1:0]  wdata_i,
    input  logic [`ADDR_W-1:0]  raddr_i,
    output logic [`DATA_W-1:0]  rdata_o
);

    logic [`DATA_W-1:0] mem_q [2**`ADDR_W];
    logic [`DATA_W-1:0] rdata_q;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // data follows address by one cycle
    always_ff @(posedge clk_i) begin
        rdata_q <= mem_q[raddr_i];
    end

    assign rdata_o = rdata_q;

endmodule

//--- load_sequencer.sv
`include "cnn_loader_config.svh"

module load_sequencer (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    start_i,
    output logic [`ADDR_W-1:0]      rd_addr_o,
    input  logic [`DATA_W-1:0]      rd_data_i,
    output loader_pkg::load_ctrl_t  ctrl_o,
    output logic [`DATA_W-1:0]      data_o,
    output logic                    busy_o,
    output logic                    done_o
);

    loader_pkg::stage_t     stage_q;
    logic                   busy_q;
    logic                   drain_q;    // last control still in flight
    logic                   done_q;
    logic                   issue;

    logic [1:0]             group;
    logic [3:0]             pos;
    loader_pkg::load_ctrl_t ctrl_d;
    loader_pkg::load_ctrl_t ctrl_q;

    assign issue = busy_q & ~drain_q;

    // stage counter
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage_q <= '0;
            busy_q  <= 1'b0;
            drain_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (start_i && !busy_q) begin
                stage_q <= '0;
                busy_q  <= 1'b1;
                drain_q <= 1'b0;
            end else if (issue) begin
                if (stage_q == `LOAD_STAGES - 1) begin
                    drain_q <= 1'b1;
                end else begin
                    stage_q <= stage_q + 1'b1;
                end
            end else if (drain_q) begin
                busy_q  <= 1'b0;
                drain_q <= 1'b0;
                done_q  <= 1'b1;    // one cycle after the final accumulate
            end
        end
    end

    // split stage into group and position within group
    always_comb begin
        if (stage_q < `GROUP_LEN) begin
            group = 2'd0;
            pos   = 4'(stage_q);
        end else if (stage_q < 2 * `GROUP_LEN) begin
            group = 2'd1;
            pos   = 4'(stage_q - 5'(`GROUP_LEN));
        end else begin
            group = 2'd2;
            pos   = 4'(stage_q - 5'(2 * `GROUP_LEN));
        end
    end

    assign rd_addr_o = `ADDR_W'({group, pos[2:0]});    // 8g + k

    always_comb begin
        ctrl_d = '0;
        if (issue) begin
            if (pos < 4'd4) begin
                ctrl_d.feature_en[pos[1:0]] = 1'b1;
            end else if (pos < 4'd8) begin
                ctrl_d.weight_en[pos[1:0]] = 1'b1;     // pe k-4
            end else begin
                ctrl_d.acc_en = '1;
            end
        end
    end

    // control lags address to match the memory read latency
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl_d;
        end
    end

    assign ctrl_o = ctrl_q;
    assign data_o = rd_data_i;  // already one cycle late out of the ram
    assign busy_o = busy_q;
    assign done_o = done_q;

endmodule

//--- operand_buffer.sv
`include "cnn_loader_config.svh"

module operand_buffer #(
    parameter type payload_t = logic [`DATA_W-1:0]
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  logic [`NUM_PE-1:0]          en_i,
    input  payload_t                    data_i,
    output payload_t [`NUM_PE-1:0]      q_o
);

    payload_t [`NUM_PE-1:0] buf_q;

    // one register per pe loaded by its own enable bit
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            buf_q <= '0;
        end else begin
            for (int k = 0; k < `NUM_PE; k++) begin
                if (en_i[k]) begin
                    buf_q[k] <= data_i;
                end
            end
        end
    end

    assign q_o = buf_q;

endmodule

//--- pe_mac.sv
`include "cnn_loader_config.svh"

module pe_mac (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    clear_i,
    input  logic                    acc_en_i,
    input  loader_pkg::feature_t    feature_i,
    input  loader_pkg::weight_t     weight_i,
    output loader_pkg::acc_t        acc_o
);

    logic signed [`DATA_W:0]        feature_ext;
    logic signed [2*`DATA_W:0]      product;
    loader_pkg::acc_t               acc_q;

    assign feature_ext = signed'({1'b0, feature_i});    // zero extend so 255 stays positive
    assign product     = feature_ext * weight_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            acc_q <= '0;
        end else if (clear_i) begin
            acc_q <= '0;
        end else if (acc_en_i) begin
            acc_q <= acc_q + loader_pkg::acc_t'(product);
        end
    end

    assign acc_o = acc_q;

endmodule

//--- apb_regs.sv
`include "cnn_loader_config.svh"

module apb_regs (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  bus_pkg::apb_req_t                   apb_i,
    output bus_pkg::apb_rsp_t                   apb_o,
    output logic                                mem_we_o,
    output logic [`ADDR_W-1:0]                  mem_waddr_o,
    output logic [`DATA_W-1:0]                  mem_wdata_o,
    output logic [`ADDR_W-1:0]                  mem_raddr_o,
    input  logic [`DATA_W-1:0]                  mem_rdata_i,
    input  logic [`ADDR_W-1:0]                  seq_raddr_i,
    output logic                                start_o,
    input  logic                                busy_i,
    input  logic                                done_i,
    input  loader_pkg::acc_t [`NUM_PE-1:0]      acc_i
);

    logic [`APB_AW-1:0]             addr;
    logic                           access;
    logic                           wr;
    logic                           aligned;
    logic                           ctrl_hit;
    logic                           status_hit;
    logic                           mem_hit;
    logic                           res_hit;
    logic                           mapped;
    logic                           host_busy;
    logic [`ADDR_W-1:0]             mem_word;
    logic [$clog2(`NUM_PE)-1:0]     res_idx;
    logic                           start_q;
    logic                           done_q;
    logic [31:0]                    rdata;

    assign addr   = apb_i.paddr;
    assign access = apb_i.psel & apb_i.penable;
    assign wr     = access & apb_i.pwrite;

    // address decode
    assign aligned    = (addr[1:0] == 2'b00);
    assign ctrl_hit   = (addr == `REG_CTRL);
    assign status_hit = (addr == `REG_STATUS);
    assign mem_hit    = aligned && (addr >= `MEM_BASE) &&
                        (addr < `MEM_BASE + 4 * (2**`ADDR_W));
    assign res_hit    = aligned && (addr >= `RES_BASE) &&
                        (addr < `RES_BASE + 4 * `NUM_PE);
    assign mapped     = ctrl_hit | status_hit | mem_hit | res_hit;

    assign mem_word = addr[`ADDR_W+1:2];
    assign res_idx  = addr[$clog2(`NUM_PE)+1:2];

    // start pulse counts as busy until the sequencer sees it
    assign host_busy = busy_i | start_q;

    assign mem_we_o    = wr & mem_hit & ~host_busy;
    assign mem_waddr_o = mem_word;
    assign mem_wdata_o = apb_i.pwdata[`DATA_W-1:0];

    // host reads take the ram port while idle with the address from the setup phase
    assign mem_raddr_o = busy_i ? seq_raddr_i : mem_word;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            start_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            start_q <= wr & ctrl_hit & apb_i.pwdata[0] & ~host_busy;
            if (start_q) begin
                done_q <= 1'b0;
            end else if (done_i) begin
                done_q <= 1'b1;     // sticky until next run
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (access && !apb_i.pwrite) begin
            if (status_hit) begin
                rdata = {30'b0, done_q, busy_i};
            end else if (mem_hit) begin
                rdata = {{(32-`DATA_W){1'b0}}, mem_rdata_i};
            end else if (res_hit) begin
                rdata = {{(32-`ACC_W){acc_i[res_idx][`ACC_W-1]}}, acc_i[res_idx]};
            end
        end
    end

    assign apb_o.prdata  = rdata;
    assign apb_o.pready  = 1'b1;   // no wait states
    assign apb_o.pslverr = access & (~mapped | (wr & mem_hit & host_busy));

    assign start_o = start_q;

endmodule

//--- loader_top.sv
`include "cnn_loader_config.svh"

module loader_top (
    input  logic                clk_i,
    input  logic                rst_i,
    input  bus_pkg::apb_req_t   apb_i,
    output bus_pkg::apb_rsp_t   apb_o
);

    logic                                       mem_we;
    logic [`ADDR_W-1:0]                         mem_waddr;
    logic [`DATA_W-1:0]                         mem_wdata;
    logic [`ADDR_W-1:0]                         mem_raddr;
    logic [`DATA_W-1:0]                         mem_rdata;
    logic [`ADDR_W-1:0]                         seq_raddr;
    logic                                       start;
    logic                                       busy;
    logic                                       done;
    loader_pkg::load_ctrl_t                     load_ctrl;
    logic [`DATA_W-1:0]                         load_data;
    loader_pkg::feature_t [`NUM_PE-1:0]         features;
    loader_pkg::weight_t [`NUM_PE-1:0]          weights;
    loader_pkg::acc_t [`NUM_PE-1:0]             acc;

    apb_regs apb_regs_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .apb_i          (apb_i),
        .apb_o          (apb_o),
        .mem_we_o       (mem_we),
        .mem_waddr_o    (mem_waddr),
        .mem_wdata_o    (mem_wdata),
        .mem_raddr_o    (mem_raddr),
        .mem_rdata_i    (mem_rdata),
        .seq_raddr_i    (seq_raddr),
        .start_o        (start),
        .busy_i         (busy),
        .done_i         (done),
        .acc_i          (acc)
    );

    data_mem data_mem_inst (
        .clk_i          (clk_i),
        .we_i           (mem_we),
        .waddr_i        (mem_waddr),
        .wdata_i        (mem_wdata),
        .raddr_i        (mem_raddr),
        .rdata_o        (mem_rdata)
    );

    load_sequencer load_sequencer_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .start_i        (start),
        .rd_addr_o      (seq_raddr),
        .rd_data_i      (mem_rdata),
        .ctrl_o         (load_ctrl),
        .data_o         (load_data),
        .busy_o         (busy),
        .done_o         (done)
    );

    operand_buffer #(.payload_t(loader_pkg::feature_t)) feature_buf_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .en_i           (load_ctrl.feature_en),
        .data_i         (loader_pkg::feature_t'(load_data)),
        .q_o            (features)
    );

    operand_buffer #(.payload_t(loader_pkg::weight_t)) weight_buf_inst (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .en_i           (load_ctrl.weight_en),
        .data_i         (loader_pkg::weight_t'(load_data)),
        .q_o            (weights)
    );

    // start also clears every accumulator
    for (genvar j = 0; j < `NUM_PE; j++) begin : gen_pe
        pe_mac pe_mac_inst (
            .clk_i      (clk_i),
            .rst_i      (rst_i),
            .clear_i    (start),
            .acc_en_i   (load_ctrl.acc_en[j]),
            .feature_i  (features[j]),
            .weight_i   (weights[j]),
            .acc_o      (acc[j])
        );
    end

endmodule

//--- loader_tb.sv
`include "cnn_loader_config.svh"

module loader_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int READY_LIMIT  = 16;   // pready never drops in this design
    localparam int DONE_LIMIT   = 200;

    logic               clk_i;
    logic               rst_i;
    bus_pkg::apb_req_t  apb_req;
    bus_pkg::apb_rsp_t  apb_rsp;

    int                 fd;
    int                 ch;
    logic [7:0]         op;
    logic [31:0]        addr;
    logic [31:0]        value;
    logic [31:0]        rdata;
    logic               err;

    loader_top loader_top_i (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .apb_i  (apb_req),
        .apb_o  (apb_rsp)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            abort_run($sformatf("Fail %s expected 0x%08h actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    // runs from a falling edge to the falling edge after the access edge
    task automatic apb_transfer(input logic write, input logic [`APB_AW-1:0] paddr,
                                input logic [31:0] pwdata, output logic [31:0] prdata,
                                output logic pslverr);
        int waits;
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = paddr;
        apb_req.pwdata  = pwdata;
        @(negedge clk_i);
        apb_req.penable = 1'b1;
        waits = 0;
        #(CLK_PERIOD / 4);      // sample mid low phase
        while (!apb_rsp.pready && waits < READY_LIMIT) begin
            @(negedge clk_i);
            #(CLK_PERIOD / 4);
            waits++;
        end
        if (!apb_rsp.pready) begin
            abort_run("the APB slave never raised pready");
        end
        prdata  = apb_rsp.prdata;
        pslverr = apb_rsp.pslverr;
        @(negedge clk_i);
        apb_req = '0;
    endtask

    task automatic apb_write(input logic [31:0] waddr, input logic [31:0] wdata,
                             output logic pslverr);
        logic [31:0] ignored;
        apb_transfer(1'b1, waddr[`APB_AW-1:0], wdata, ignored, pslverr);
    endtask

    task automatic apb_read(input logic [31:0] raddr, output logic [31:0] prdata,
                            output logic pslverr);
        apb_transfer(1'b0, raddr[`APB_AW-1:0], 32'd0, prdata, pslverr);
    endtask

    task automatic poll_done();
        logic [31:0] status;
        logic        status_err;
        int          cycles;
        status = '0;
        cycles = 0;
        while (!status[1]) begin
            if (cycles >= DONE_LIMIT) begin
                abort_run("the loader never finished, no done within 200 cycles");
            end
            apb_read(`REG_STATUS, status, status_err);
            check_value("P status pslverr", 32'd0, {31'b0, status_err});
            cycles += 2;    // setup plus access
        end
    endtask

    initial begin
        rst_i   = 1'b1;
        apb_req = '0;
        fd = $fopen("loader_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open loader_input.txt");
        end
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_i = 1'b0;
        while ($fscanf(fd, " %c", op) == 1) begin
            case (op)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin  // rest of comment line
                        ch = $fgetc(fd);
                    end
                end
                "W", "E": begin
                    if ($fscanf(fd, "%h %h", addr, value) != 2) begin
                        abort_run("a write line in loader_input.txt lacks address or data");
                    end
                    apb_write(addr, value, err);
                    check_value($sformatf("%c 0x%03h pslverr", op, addr[11:0]),
                                {31'b0, op == "E"}, {31'b0, err});
                end
                "R": begin
                    if ($fscanf(fd, "%h %h", addr, value) != 2) begin
                        abort_run("a read line in loader_input.txt lacks address or value");
                    end
                    apb_read(addr, rdata, err);
                    check_value($sformatf("R 0x%03h pslverr", addr[11:0]), 32'd0, {31'b0, err});
                    check_value($sformatf("R 0x%03h data", addr[11:0]), value, rdata);
                end
                "X": begin
                    if ($fscanf(fd, "%h", addr) != 1) begin
                        abort_run("an X line in loader_input.txt lacks its address");
                    end
                    apb_read(addr, rdata, err);
                    check_value($sformatf("X 0x%03h pslverr", addr[11:0]), 32'd1, {31'b0, err});
                end
                "S": begin
                    apb_write(`REG_CTRL, 32'h1, err);
                    check_value("S ctrl pslverr", 32'd0, {31'b0, err});
                end
                "P": poll_done();
                default: abort_run($sformatf("unknown opcode %c in loader_input.txt", op));
            endcase
        end
        $fclose(fd);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- project.f
+incdir+.
bus_pkg.sv
loader_pkg.sv
data_mem.sv
load_sequencer.sv
operand_buffer.sv
pe_mac.sv
apb_regs.sv
loader_top.sv
loader_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP       = loader_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- loader_input.txt
# op addr value, all hex: W write, E write expecting pslverr, R read and compare
# X read expecting pslverr, S start a run, P poll STATUS until done
R 004 0
R 200 0
R 204 0
R 208 0
R 20C 0
W 100 FF
W 104 10
W 108 03
W 10C 80
W 110 02
W 114 FE
W 118 7F
W 11C 81
W 120 01
W 124 FF
W 128 20
W 12C 00
W 130 80
W 134 05
W 138 FF
W 13C 40
W 140 FF
W 144 07
W 148 11
W 14C 64
W 150 FF
W 154 80
W 158 03
W 15C 7F
R 100 FF
R 114 FE
R 15C 7F
S
E 100 55
P
R 004 2
R 200 7F
R 204 15B
R 208 190
R 20C FFFFF21C
R 100 FF
X 300
W 110 03
W 114 FD
W 118 00
W 11C 01
S
P
R 004 2
R 200 17E
R 204 14B
R 208 13
R 20C 321C
